/* verilog/glb_geometry_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// global buffer address geometry and the vector types built on it
// a byte address splits, from the top, into tile, bank select and bank offset
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package glb_geometry_pkg;

    localparam int DATA_WIDTH = 64;
    localparam int STRB_WIDTH = 8;
    localparam int BYTE_OFFSET_WIDTH = 3;
    localparam int BANK_WORD_ADDR_WIDTH = 5;
    localparam int BANK_ADDR_WIDTH = BANK_WORD_ADDR_WIDTH + BYTE_OFFSET_WIDTH;
    localparam int BANK_SEL_ADDR_WIDTH = 2;
    localparam int BANKS_PER_TILE = 2 ** BANK_SEL_ADDR_WIDTH;
    localparam int TILE_SEL_ADDR_WIDTH = 2;
    localparam int GLB_ADDR_WIDTH = TILE_SEL_ADDR_WIDTH + BANK_SEL_ADDR_WIDTH + BANK_ADDR_WIDTH;

    typedef logic [GLB_ADDR_WIDTH-1:0] glb_addr_t;
    typedef logic [DATA_WIDTH-1:0] glb_data_t;
    typedef logic [STRB_WIDTH-1:0] glb_strb_t;
    typedef logic [TILE_SEL_ADDR_WIDTH-1:0] tile_id_t;
    typedef logic [BANK_SEL_ADDR_WIDTH-1:0] bank_sel_t;
    typedef logic [BANK_WORD_ADDR_WIDTH-1:0] bank_word_addr_t;

    // address field pickers
    function automatic tile_id_t addr_tile(glb_addr_t addr);
        return addr[BANK_ADDR_WIDTH + BANK_SEL_ADDR_WIDTH +: TILE_SEL_ADDR_WIDTH];
    endfunction

    function automatic bank_sel_t addr_bank(glb_addr_t addr);
        return addr[BANK_ADDR_WIDTH +: BANK_SEL_ADDR_WIDTH];
    endfunction

    // byte offset inside the word is dropped
    function automatic bank_word_addr_t addr_word(glb_addr_t addr);
        return addr[BYTE_OFFSET_WIDTH +: BANK_WORD_ADDR_WIDTH];
    endfunction

endpackage

`default_nettype wire

/* verilog/glb_packet_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// packet formats exchanged by the tile switch and its neighbors
// a packet is valid in the cycle its enable bit is high
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package glb_packet_pkg;

    import glb_geometry_pkg::*;

    // write request
    typedef struct packed {
        logic      wr_en;
        glb_strb_t wr_strb;
        glb_addr_t wr_addr;
        glb_data_t wr_data;
    } wr_packet_t;

    // read request
    typedef struct packed {
        logic      rd_en;
        glb_addr_t rd_addr;
    } rdrq_packet_t;

    // read response
    typedef struct packed {
        logic      rd_data_valid;
        glb_data_t rd_data;
    } rdrs_packet_t;

    // owner of a read in flight
    typedef enum logic [1:0] {
        NONE     = 2'd0,
        PROC     = 2'd1,
        STRM_DMA = 2'd2,
        STRM_RTR = 2'd3
    } rdrq_src_t;

endpackage

`default_nettype wire

/* verilog/glb_bank_if.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// link between the core switch and one memory bank
// the switch drives requests, the bank answers with registered read data
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

interface glb_bank_if;

    import glb_geometry_pkg::*;

    // request side
    logic            wr_en;
    glb_strb_t       wr_strb;
    bank_word_addr_t wr_word_addr;
    glb_data_t       wr_data;
    logic            rd_en;
    bank_word_addr_t rd_word_addr;

    // response side
    logic            rd_data_valid;
    glb_data_t       rd_data;

    modport switch_mp (
        output wr_en, wr_strb, wr_word_addr, wr_data, rd_en, rd_word_addr,
        input  rd_data_valid, rd_data
    );

    modport bank_mp (
        input  wr_en, wr_strb, wr_word_addr, wr_data, rd_en, rd_word_addr,
        output rd_data_valid, rd_data
    );

endinterface

`default_nettype wire

/* verilog/glb_bank.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one global buffer bank, byte-maskable memory with a one-cycle read
// a read and a write to the same word in one cycle return the old word
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module glb_bank (
    input  logic        clk,
    input  logic        reset,
    glb_bank_if.bank_mp bank
);

    import glb_geometry_pkg::*;

    localparam int WORDS = 2 ** BANK_WORD_ADDR_WIDTH;
    localparam int BYTE_WIDTH = DATA_WIDTH / STRB_WIDTH;

    glb_data_t mem [WORDS];

    // storage and read port
    always_ff @(posedge clk) begin
        if (bank.wr_en) begin
            for (int b = 0; b < STRB_WIDTH; b++) begin
                if (bank.wr_strb[b]) begin
                    mem[bank.wr_word_addr][b*BYTE_WIDTH +: BYTE_WIDTH] <=
                        bank.wr_data[b*BYTE_WIDTH +: BYTE_WIDTH];
                end
            end
        end
        if (bank.rd_en) begin
            bank.rd_data <= mem[bank.rd_word_addr];
        end
    end

    // valid follows the request by one edge
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bank.rd_data_valid <= 1'b0;
        end else begin
            bank.rd_data_valid <= bank.rd_en;
        end
    end

    // read latency is exactly one edge
    a_rd_latency: assert property (
        @(posedge clk) disable iff (reset)
        bank.rd_data_valid == $past(bank.rd_en)
    ) else $error("bank read valid out of step with its request");

endmodule

`default_nettype wire

/* verilog/glb_core_switch.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tile core switch, filters packets by tile id and steers them to the banks
// processor path runs every cycle, stream paths advance only under clk_en
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module glb_core_switch (
    input  logic                        clk,
    input  logic                        clk_en,
    input  logic                        reset,
    input  glb_geometry_pkg::tile_id_t  glb_tile_id,
    input  logic [1:0]                  cfg_st_dma_mode,
    input  logic [1:0]                  cfg_ld_dma_mode,

    input  glb_packet_pkg::wr_packet_t   wr_packet_pr2sw,
    input  glb_packet_pkg::rdrq_packet_t rdrq_packet_pr2sw,
    output glb_packet_pkg::rdrs_packet_t rdrs_packet_sw2pr,

    input  glb_packet_pkg::wr_packet_t   wr_packet_d2sw,
    input  glb_packet_pkg::rdrq_packet_t rdrq_packet_d2sw,
    output glb_packet_pkg::rdrs_packet_t rdrs_packet_sw2d,

    input  glb_packet_pkg::wr_packet_t   wr_packet_sr2sw,
    input  glb_packet_pkg::rdrq_packet_t rdrq_packet_sr2sw,
    input  glb_packet_pkg::rdrs_packet_t rdrs_packet_sr2sw,
    output glb_packet_pkg::wr_packet_t   wr_packet_sw2sr,
    output glb_packet_pkg::rdrq_packet_t rdrq_packet_sw2sr,
    output glb_packet_pkg::rdrs_packet_t rdrs_packet_sw2sr,

    glb_bank_if.switch_mp bank [glb_geometry_pkg::BANKS_PER_TILE]
);

    import glb_geometry_pkg::*;
    import glb_packet_pkg::*;

    logic         st_dma_on;
    logic         ld_dma_on;
    logic         clk_en_q;

    wr_packet_t   wr_pr_q, wr_d_q, wr_sr_q;
    wr_packet_t   wr_sel;
    logic         wr_hit;
    bank_sel_t    wr_bank;

    rdrq_packet_t rdrq_pr_q, rdrq_d_q, rdrq_sr_q;
    rdrq_packet_t rdrq_sel;
    rdrq_src_t    rd_src;
    bank_sel_t    rd_bank;

    // owner records for the two paths
    rdrq_src_t    pr_src_d1, pr_src_d2;
    bank_sel_t    pr_bank_d1;
    rdrq_src_t    strm_src_d1, strm_src_d2;
    bank_sel_t    strm_bank_d1;

    rdrs_packet_t bank_rdrs [BANKS_PER_TILE];
    rdrs_packet_t pr_rdrs_q;
    rdrs_packet_t strm_hold_q;
    rdrs_packet_t strm_rdrs_q;
    rdrs_packet_t rdrs_sr_q;

    logic [BANKS_PER_TILE-1:0] bank_wr_en;
    logic [BANKS_PER_TILE-1:0] bank_rd_en;

    assign st_dma_on = (cfg_st_dma_mode != 2'b00);
    assign ld_dma_on = (cfg_ld_dma_mode != 2'b00);

    // processor inputs, never stalled
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_pr_q   <= '0;
            rdrq_pr_q <= '0;
            clk_en_q  <= 1'b0;
        end else begin
            wr_pr_q   <= wr_packet_pr2sw;
            rdrq_pr_q <= rdrq_packet_pr2sw;
            clk_en_q  <= clk_en;
        end
    end

    // stream inputs
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_d_q    <= '0;
            wr_sr_q   <= '0;
            rdrq_d_q  <= '0;
            rdrq_sr_q <= '0;
        end else if (clk_en) begin
            wr_d_q    <= wr_packet_d2sw;
            wr_sr_q   <= wr_packet_sr2sw;
            rdrq_d_q  <= rdrq_packet_d2sw;
            rdrq_sr_q <= rdrq_packet_sr2sw;
        end
    end

    // write select, stream writes land only on an enabled edge
    always_comb begin
        if (wr_pr_q.wr_en) begin
            wr_sel = wr_pr_q;
        end else if (!clk_en) begin
            wr_sel = '0;
        end else if (st_dma_on) begin
            wr_sel = wr_d_q;
        end else begin
            wr_sel = wr_sr_q;
        end
    end

    assign wr_hit  = wr_sel.wr_en && (addr_tile(wr_sel.wr_addr) == glb_tile_id);
    assign wr_bank = addr_bank(wr_sel.wr_addr);

    // read arbitration
    always_comb begin
        rd_src = NONE;
        if (rdrq_pr_q.rd_en && addr_tile(rdrq_pr_q.rd_addr) == glb_tile_id) begin
            rd_src = PROC;
        end else if (clk_en && ld_dma_on && rdrq_d_q.rd_en &&
                     addr_tile(rdrq_d_q.rd_addr) == glb_tile_id) begin
            rd_src = STRM_DMA;
        end else if (clk_en && !ld_dma_on && rdrq_sr_q.rd_en &&
                     addr_tile(rdrq_sr_q.rd_addr) == glb_tile_id) begin
            rd_src = STRM_RTR;
        end
    end

    always_comb begin
        case (rd_src)
            PROC:     rdrq_sel = rdrq_pr_q;
            STRM_DMA: rdrq_sel = rdrq_d_q;
            STRM_RTR: rdrq_sel = rdrq_sr_q;
            default:  rdrq_sel = '0;
        endcase
    end

    assign rd_bank = addr_bank(rdrq_sel.rd_addr);

    // bank steering
    for (genvar i = 0; i < BANKS_PER_TILE; i++) begin : g_bank
        assign bank_wr_en[i] = wr_hit && (wr_bank == bank_sel_t'(i));
        assign bank_rd_en[i] = (rd_src != NONE) && (rd_bank == bank_sel_t'(i));

        assign bank[i].wr_en        = bank_wr_en[i];
        assign bank[i].wr_strb      = wr_sel.wr_strb;
        assign bank[i].wr_word_addr = addr_word(wr_sel.wr_addr);
        assign bank[i].wr_data      = wr_sel.wr_data;
        assign bank[i].rd_en        = bank_rd_en[i];
        assign bank[i].rd_word_addr = addr_word(rdrq_sel.rd_addr);

        assign bank_rdrs[i] = '{rd_data_valid: bank[i].rd_data_valid,
                                rd_data:       bank[i].rd_data};
    end

    // processor return path
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pr_src_d1  <= NONE;
            pr_src_d2  <= NONE;
            pr_bank_d1 <= '0;
            pr_rdrs_q  <= '0;
        end else begin
            pr_src_d1  <= rd_src;
            pr_bank_d1 <= rd_bank;
            pr_src_d2  <= pr_src_d1;
            pr_rdrs_q  <= bank_rdrs[pr_bank_d1];
        end
    end

    // bank data is only good on the edge right after the enabled read edge,
    // so catch it there in case the next enabled edge is later
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            strm_hold_q <= '0;
        end else if (clk_en_q) begin
            strm_hold_q <= bank_rdrs[strm_bank_d1];
        end
    end

    // stream return path
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            strm_src_d1  <= NONE;
            strm_src_d2  <= NONE;
            strm_bank_d1 <= '0;
            strm_rdrs_q  <= '0;
            rdrs_sr_q    <= '0;
        end else if (clk_en) begin
            strm_src_d1  <= rd_src;
            strm_bank_d1 <= rd_bank;
            strm_src_d2  <= strm_src_d1;
            strm_rdrs_q  <= clk_en_q ? bank_rdrs[strm_bank_d1] : strm_hold_q;
            rdrs_sr_q    <= rdrs_packet_sr2sw;
        end
    end

    assign rdrs_packet_sw2pr = (pr_src_d2 == PROC) ? pr_rdrs_q : '0;
    assign rdrs_packet_sw2d  = ld_dma_on ? rdrs_sr_q : '0;

    always_comb begin
        if (strm_src_d2 == STRM_DMA || strm_src_d2 == STRM_RTR) begin
            rdrs_packet_sw2sr = strm_rdrs_q;
        end else if (ld_dma_on) begin
            rdrs_packet_sw2sr = '0;
        end else begin
            rdrs_packet_sw2sr = rdrs_packet_sr2sw;
        end
    end

    // forwarding to the next tile
    assign wr_packet_sw2sr   = st_dma_on ? wr_packet_d2sw : wr_packet_sr2sw;
    assign rdrq_packet_sw2sr = ld_dma_on ? rdrq_packet_d2sw : rdrq_packet_sr2sw;

    a_one_bank: assert property (
        @(posedge clk) disable iff (reset)
        $onehot0(bank_wr_en) && $onehot0(bank_rd_en)
    ) else $error("more than one bank enabled in a cycle");

    // a processor win must come back as valid bank data two edges later
    a_pr_resp_valid: assert property (
        @(posedge clk) disable iff (reset)
        (pr_src_d2 == PROC) |-> rdrs_packet_sw2pr.rd_data_valid
    ) else $error("processor response without valid bank data");

endmodule

`default_nettype wire

/* verilog/glb_tile.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one global buffer tile, core switch in front of four memory banks
// top level of the design, chained to neighbor tiles through the router ports
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module glb_tile (
    input  logic                         clk,
    input  logic                         clk_en,
    input  logic                         reset,
    input  glb_geometry_pkg::tile_id_t   glb_tile_id,
    input  logic [1:0]                   cfg_st_dma_mode,
    input  logic [1:0]                   cfg_ld_dma_mode,

    // processor
    input  glb_packet_pkg::wr_packet_t   wr_packet_pr2sw,
    input  glb_packet_pkg::rdrq_packet_t rdrq_packet_pr2sw,
    output glb_packet_pkg::rdrs_packet_t rdrs_packet_sw2pr,

    // stream dma
    input  glb_packet_pkg::wr_packet_t   wr_packet_d2sw,
    input  glb_packet_pkg::rdrq_packet_t rdrq_packet_d2sw,
    output glb_packet_pkg::rdrs_packet_t rdrs_packet_sw2d,

    // stream router, in from the previous tile and out to the next
    input  glb_packet_pkg::wr_packet_t   wr_packet_sr2sw,
    input  glb_packet_pkg::rdrq_packet_t rdrq_packet_sr2sw,
    input  glb_packet_pkg::rdrs_packet_t rdrs_packet_sr2sw,
    output glb_packet_pkg::wr_packet_t   wr_packet_sw2sr,
    output glb_packet_pkg::rdrq_packet_t rdrq_packet_sw2sr,
    output glb_packet_pkg::rdrs_packet_t rdrs_packet_sw2sr
);

    import glb_geometry_pkg::*;

    glb_bank_if bank_if [BANKS_PER_TILE] ();

    glb_core_switch u_core_switch (
        .clk               (clk),
        .clk_en            (clk_en),
        .reset             (reset),
        .glb_tile_id       (glb_tile_id),
        .cfg_st_dma_mode   (cfg_st_dma_mode),
        .cfg_ld_dma_mode   (cfg_ld_dma_mode),
        .wr_packet_pr2sw   (wr_packet_pr2sw),
        .rdrq_packet_pr2sw (rdrq_packet_pr2sw),
        .rdrs_packet_sw2pr (rdrs_packet_sw2pr),
        .wr_packet_d2sw    (wr_packet_d2sw),
        .rdrq_packet_d2sw  (rdrq_packet_d2sw),
        .rdrs_packet_sw2d  (rdrs_packet_sw2d),
        .wr_packet_sr2sw   (wr_packet_sr2sw),
        .rdrq_packet_sr2sw (rdrq_packet_sr2sw),
        .rdrs_packet_sr2sw (rdrs_packet_sr2sw),
        .wr_packet_sw2sr   (wr_packet_sw2sr),
        .rdrq_packet_sw2sr (rdrq_packet_sw2sr),
        .rdrs_packet_sw2sr (rdrs_packet_sw2sr),
        .bank              (bank_if)
    );

    // banks see only the processor clock, stalls live in the switch
    for (genvar i = 0; i < BANKS_PER_TILE; i++) begin : g_bank
        glb_bank u_bank (
            .clk   (clk),
            .reset (reset),
            .bank  (bank_if[i])
        );
    end

endmodule

`default_nettype wire

/* verification/glb_tile_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for one global buffer tile, reference memory plus expected responses
// outputs are checked by concurrent assertions on the falling clock edge
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module glb_tile_tb;

    import glb_geometry_pkg::*;
    import glb_packet_pkg::*;

    localparam tile_id_t TILE = 2'd2;
    localparam int WORDS = 128;
    localparam int N_OPS = 16;
    // reset, fill, four mode changes, the six phases and the final drain
    localparam int STIM_CYCLES = 4 + WORDS + 4 * 8 + 2 * N_OPS + 2 * N_OPS + 5 * N_OPS
                               + N_OPS + 2 * N_OPS + 9 * (N_OPS / 4) + 12;
    localparam int TIMEOUT = 2 * STIM_CYCLES;
    localparam int ARR = 4 * TIMEOUT;

    logic clk = 1'b0;
    logic clk_en, reset;
    tile_id_t glb_tile_id;
    logic [1:0] cfg_st_dma_mode, cfg_ld_dma_mode;
    wr_packet_t wr_packet_pr2sw, wr_packet_d2sw, wr_packet_sr2sw, wr_packet_sw2sr;
    rdrq_packet_t rdrq_packet_pr2sw, rdrq_packet_d2sw, rdrq_packet_sr2sw, rdrq_packet_sw2sr;
    rdrs_packet_t rdrs_packet_sw2pr, rdrs_packet_sw2d, rdrs_packet_sr2sw, rdrs_packet_sw2sr;

    int cyc = 0;
    int en_cnt = 0;
    int errors = 0;
    logic [15:0] lfsr = 16'd35;
    bit [63:0] ref_mem [WORDS];
    // expected responses, by cycle for the processor and by enabled edge for streams
    bit exp_pr_v [ARR];
    bit [63:0] exp_pr_d [ARR];
    bit exp_st_v [ARR];
    bit [63:0] exp_st_d [ARR];

    logic st_on, ld_on;
    rdrs_packet_t pr_exp, st_exp, sw2sr_exp, sw2d_exp, rdrs_sr_model;
    wr_packet_t fwd_wr_exp;
    rdrq_packet_t fwd_rq_exp;

    glb_tile i_dut (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (clk_en) begin
            en_cnt <= en_cnt + 1;
            rdrs_sr_model <= rdrs_packet_sr2sw;
        end
        if (reset) begin
            rdrs_sr_model <= '0;
        end
        if (cyc > TIMEOUT) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT);
            $display(">>> FAIL");
            $finish;
        end
    end

    assign st_on = (cfg_st_dma_mode != 2'b00);
    assign ld_on = (cfg_ld_dma_mode != 2'b00);
    assign pr_exp = exp_pr_v[cyc] ? {1'b1, exp_pr_d[cyc]} : '0;
    assign st_exp = exp_st_v[en_cnt] ? {1'b1, exp_st_d[en_cnt]} : '0;
    assign sw2d_exp = ld_on ? rdrs_sr_model : '0;
    assign fwd_wr_exp = st_on ? wr_packet_d2sw : wr_packet_sr2sw;
    assign fwd_rq_exp = ld_on ? rdrq_packet_d2sw : rdrq_packet_sr2sw;

    // a local stream response takes the router output, else pass-through
    always_comb begin
        if (st_exp.rd_data_valid) begin
            sw2sr_exp = st_exp;
        end else if (ld_on) begin
            sw2sr_exp = '0;
        end else begin
            sw2sr_exp = rdrs_packet_sr2sw;
        end
    end

    a_sw2pr: assert property (@(negedge clk) disable iff (reset)
        rdrs_packet_sw2pr == pr_exp)
    else begin
        errors++;
        $display("ERR rdrs_packet_sw2pr got %h exp %h", $sampled(rdrs_packet_sw2pr),
                 $sampled(pr_exp));
    end

    a_sw2sr: assert property (@(negedge clk) disable iff (reset)
        rdrs_packet_sw2sr == sw2sr_exp)
    else begin
        errors++;
        $display("ERR rdrs_packet_sw2sr got %h exp %h", $sampled(rdrs_packet_sw2sr),
                 $sampled(sw2sr_exp));
    end

    a_sw2d: assert property (@(negedge clk) disable iff (reset)
        rdrs_packet_sw2d == sw2d_exp)
    else begin
        errors++;
        $display("ERR rdrs_packet_sw2d got %h exp %h", $sampled(rdrs_packet_sw2d),
                 $sampled(sw2d_exp));
    end

    a_fwd_wr: assert property (@(negedge clk) disable iff (reset)
        wr_packet_sw2sr == fwd_wr_exp)
    else begin
        errors++;
        $display("ERR wr_packet_sw2sr got %h exp %h", $sampled(wr_packet_sw2sr),
                 $sampled(fwd_wr_exp));
    end

    a_fwd_rq: assert property (@(negedge clk) disable iff (reset)
        rdrq_packet_sw2sr == fwd_rq_exp)
    else begin
        errors++;
        $display("ERR rdrq_packet_sw2sr got %h exp %h", $sampled(rdrq_packet_sw2sr),
                 $sampled(fwd_rq_exp));
    end

    // galois lfsr, one step per bit taken
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[62:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        end
        return r;
    endfunction

    function automatic glb_addr_t rand_addr(input tile_id_t tile);
        logic [63:0] bank_bits;
        logic [63:0] word_bits;
        bank_bits = rand_bits(2);
        word_bits = rand_bits(5);
        return {tile, bank_bits[1:0], word_bits[4:0], 3'b000};
    endfunction

    // bank select and word index the reference memory
    function automatic int mem_idx(input glb_addr_t addr);
        return int'(addr[9:3]);
    endfunction

    function automatic logic [63:0] merge(input logic [63:0] old, input logic [63:0] data,
                                          input glb_strb_t strb);
        logic [63:0] r;
        r = old;
        for (int b = 0; b < 8; b++) begin
            if (strb[b]) begin
                r[b*8 +: 8] = data[b*8 +: 8];
            end
        end
        return r;
    endfunction

    // falling edge, requests back to idle, fresh router response
    task automatic next_cycle();
        logic [63:0] v;
        @(negedge clk);
        clk_en = 1'b1;
        wr_packet_pr2sw = '0;
        rdrq_packet_pr2sw = '0;
        wr_packet_d2sw = '0;
        rdrq_packet_d2sw = '0;
        wr_packet_sr2sw = '0;
        rdrq_packet_sr2sw = '0;
        v = rand_bits(1);
        rdrs_packet_sr2sw = {v[0], rand_bits(64)};
    endtask

    task automatic idle(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic proc_write(input glb_addr_t addr, input glb_strb_t strb,
                              input logic [63:0] data);
        wr_packet_pr2sw = '{wr_en: 1'b1, wr_strb: strb, wr_addr: addr, wr_data: data};
        if (addr_tile(addr) == TILE) begin
            ref_mem[mem_idx(addr)] = merge(ref_mem[mem_idx(addr)], data, strb);
        end
    endtask

    task automatic proc_read(input glb_addr_t addr);
        rdrq_packet_pr2sw = '{rd_en: 1'b1, rd_addr: addr};
        if (addr_tile(addr) == TILE) begin
            exp_pr_v[cyc + 3] = 1'b1;
            exp_pr_d[cyc + 3] = ref_mem[mem_idx(addr)];
        end
    endtask

    // a processor write in the same cycle wins over any stream write
    task automatic strm_write(input bit from_dma, input glb_addr_t addr,
                              input glb_strb_t strb, input logic [63:0] data);
        wr_packet_t p;
        p = '{wr_en: 1'b1, wr_strb: strb, wr_addr: addr, wr_data: data};
        if (from_dma) begin
            wr_packet_d2sw = p;
        end else begin
            wr_packet_sr2sw = p;
        end
        if (addr_tile(addr) == TILE && from_dma == st_on && !wr_packet_pr2sw.wr_en) begin
            ref_mem[mem_idx(addr)] = merge(ref_mem[mem_idx(addr)], data, strb);
        end
    endtask

    task automatic strm_read(input bit from_dma, input glb_addr_t addr);
        bit pr_hit;
        pr_hit = rdrq_packet_pr2sw.rd_en && addr_tile(rdrq_packet_pr2sw.rd_addr) == TILE;
        if (from_dma) begin
            rdrq_packet_d2sw = '{rd_en: 1'b1, rd_addr: addr};
        end else begin
            rdrq_packet_sr2sw = '{rd_en: 1'b1, rd_addr: addr};
        end
        if (addr_tile(addr) == TILE && from_dma == ld_on && !pr_hit) begin
            exp_st_v[en_cnt + 3] = 1'b1;
            exp_st_d[en_cnt + 3] = ref_mem[mem_idx(addr)];
        end
    endtask

    task automatic set_modes(input logic [1:0] st, input logic [1:0] ld);
        idle(4);
        cfg_st_dma_mode = st;
        cfg_ld_dma_mode = ld;
        idle(4);
    endtask

    initial begin
        glb_addr_t a, b;
        logic [63:0] d;
        reset = 1'b1;
        clk_en = 1'b0;
        glb_tile_id = TILE;
        cfg_st_dma_mode = 2'b00;
        cfg_ld_dma_mode = 2'b00;
        wr_packet_pr2sw = '0;
        rdrq_packet_pr2sw = '0;
        wr_packet_d2sw = '0;
        rdrq_packet_d2sw = '0;
        wr_packet_sr2sw = '0;
        rdrq_packet_sr2sw = '0;
        rdrs_packet_sr2sw = '0;
        repeat (4) @(negedge clk);
        reset = 1'b0;

        // fill every word so reads never see unwritten data
        for (int i = 0; i < WORDS; i++) begin
            next_cycle();
            proc_write({TILE, i[6:0], 3'b000}, 8'hff, rand_bits(64));
        end

        // processor writes with random strobes, then read back
        for (int i = 0; i < N_OPS; i++) begin
            a = rand_addr(TILE);
            next_cycle();
            proc_write(a, rand_bits(8), rand_bits(64));
            next_cycle();
            proc_read(a);
        end

        // both dmas on
        set_modes(2'b01, 2'b01);
        for (int i = 0; i < N_OPS; i++) begin
            a = rand_addr(TILE);
            next_cycle();
            strm_write(1'b1, a, rand_bits(8), rand_bits(64));
            next_cycle();
            strm_read(1'b1, a);
        end

        // dmas off, router traffic for this tile and for another one
        set_modes(2'b00, 2'b00);
        for (int i = 0; i < N_OPS; i++) begin
            a = rand_addr(TILE);
            b = rand_addr(2'd1);
            next_cycle();
            strm_write(1'b0, a, rand_bits(8), rand_bits(64));
            next_cycle();
            strm_write(1'b0, b, 8'hff, rand_bits(64));
            next_cycle();
            strm_read(1'b0, a);
            next_cycle();
            strm_read(1'b0, b);
            next_cycle();
            proc_read({TILE, b[9:0]});
        end

        // load dma on, router responses registered toward the dma
        set_modes(2'b00, 2'b10);
        idle(N_OPS);

        // processor against dma in the same cycle
        set_modes(2'b11, 2'b11);
        for (int i = 0; i < N_OPS; i++) begin
            a = rand_addr(TILE);
            b = rand_addr(TILE);
            next_cycle();
            proc_write(a, 8'hff, rand_bits(64));
            strm_write(1'b1, a, 8'hff, rand_bits(64));
            next_cycle();
            proc_read(a);
            strm_read(1'b1, b);
        end

        // stalls in the middle of stream reads
        for (int i = 0; i < N_OPS / 4; i++) begin
            a = rand_addr(TILE);
            next_cycle();
            strm_read(1'b1, a);
            next_cycle();
            clk_en = 1'b0;
            proc_read(rand_addr(TILE));
            next_cycle();
            clk_en = 1'b0;
            next_cycle();
            clk_en = 1'b0;
            proc_read(rand_addr(TILE));
            next_cycle();
            clk_en = 1'b0;
            next_cycle();
            strm_read(1'b1, rand_addr(TILE));
            next_cycle();
            clk_en = 1'b0;
            next_cycle();
            clk_en = 1'b0;
            next_cycle();
            d = rand_bits(1);
            clk_en = d[0];
        end
        idle(12);

        $display("checks done after %0d cycles, errors: %0d", cyc, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
verilog/glb_geometry_pkg.sv
verilog/glb_packet_pkg.sv
verilog/glb_bank_if.sv
verilog/glb_bank.sv
verilog/glb_core_switch.sv
verilog/glb_tile.sv
verification/glb_tile_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := glb_tile_tb
RTL_TOP   := glb_tile
FILELIST  := project.f
BUILD_DIR := obj_dir
LOG       := sim.log
VFLAGS    := --binary --timing --assert -j 0
LFLAGS    := --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then exit 1; fi
	@grep -q ">>> PASS" $(LOG)

lint:
	$(VERILATOR) $(LFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
